/* all.f */
vcu_pkg.sv
vcu_issue_ctrl.sv
vcu_hazard_tracker.sv
vcu_vtype_regs.sv
vcu_decoder.sv
vcu_top.sv
tb_vcu.sv

/* Makefile */
TOP := tb_vcu

.PHONY: help test clean

help:
	@echo "make test   build and run the testbench with Verilator"
	@echo "make clean  remove the build directory"
	@echo "make help   list these targets"

test:
	verilator --binary -j 0 --top-module $(TOP) -f all.f -o V$(TOP)
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

/* tb_vcu.sv */
// vector control unit testbench with clock, reset, stimulus tasks, directed tests and checks
`timescale 1ns/1ps

module tb_vcu;

   localparam int TIMEOUT = 50; // cycles allowed per wait

   logic                            clk;
   logic                            rstn;
   vcu_pkg::instr_req_t             req_i;
   logic                            req_vld_i;
   logic                            req_rdy_o;
   logic [vcu_pkg::W_PORTS_NUM-1:0] start_o;
   vcu_pkg::dispatch_t              dispatch_o;
   logic [vcu_pkg::W_PORTS_NUM-1:0] port_done_i;
   logic [vcu_pkg::VL_W-1:0]        vl_o;
   logic [2:0]                      sew_o;
   logic [2:0]                      lmul_o;

   int          cyc;     // rising edges so far
   int          seed;
   logic [31:0] cur_vl;  // model of vl
   logic [2:0]  cur_sew; // model of sew

   vcu_top vcu_top_inst (
      .clk         (clk),
      .rstn        (rstn),
      .req_i       (req_i),
      .req_vld_i   (req_vld_i),
      .req_rdy_o   (req_rdy_o),
      .start_o     (start_o),
      .dispatch_o  (dispatch_o),
      .port_done_i (port_done_i),
      .vl_o        (vl_o),
      .sew_o       (sew_o),
      .lmul_o      (lmul_o)
   );

   always #5 clk = ~clk;

   always @(posedge clk)
      cyc <= cyc + 1;

   task automatic fail_run(input string msg);
      $display("TB FAILED");
      $fatal(1, "%s", msg);
   endtask

   task automatic check(input string tname, input logic [31:0] exp, input logic [31:0] act);
      if (exp !== act)
      begin
         $display("ERROR %s: expected %0h, actual %0h", tname, exp, act);
         $display("TB FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   function automatic logic [31:0] next_rand();
      return $random(seed);
   endfunction

   // OP-V arithmetic word
   function automatic logic [31:0] op_v(input logic [5:0] funct6, input logic vm,
         input logic [4:0] vs2, input logic [4:0] vs1, input logic [2:0] funct3,
         input logic [4:0] vd);
      return {funct6, vm, vs2, vs1, funct3, vd, 7'h57};
   endfunction

   function automatic logic [31:0] vsetvli(input logic [4:0] vd, input logic [4:0] rs1,
         input logic [2:0] sew, input logic [2:0] lmul);
      logic [31:0] ins;
      ins        = 32'h0000_7057; // funct3 111
      ins[25]    = lmul[2];       // fractional lmul flag
      ins[24:22] = sew;
      ins[21:20] = lmul[1:0];
      ins[19:15] = rs1;
      ins[11:7]  = vd;
      return ins;
   endfunction

   // elements per group for a given sew and lmul
   function automatic logic [31:0] vlmax_ref(input logic [2:0] sew, input logic [2:0] lmul);
      int elems;
      elems = (vcu_pkg::VLEN / 8) >> sew; // one register
      if (lmul < 3'd4)
         return elems << lmul;
      else
         return elems >> (8 - int'(lmul)); // 1/8 .. 1/2
   endfunction

   function automatic vcu_pkg::instr_req_t make_req(input logic [31:0] instr,
         input logic [31:0] rs1, input vcu_pkg::instr_class_e cls);
      vcu_pkg::instr_req_t r;
      r.instr = instr;
      r.rs1   = rs1;
      r.cls   = cls;
      return r;
   endfunction

   task automatic send(input vcu_pkg::instr_req_t r);
      int n;
      n = 0;
      @(posedge clk);
      #1;
      req_i     = r;
      req_vld_i = 1'b1;
      @(negedge clk);
      while (!req_rdy_o && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (!req_rdy_o)
         fail_run("timeout, the DUT never accepted the instruction");
      @(posedge clk); // accept edge
      #1;
      req_vld_i = 1'b0;
   endtask

   task automatic wait_start(output logic [3:0] st, output vcu_pkg::dispatch_t d);
      int n;
      n = 0;
      @(negedge clk);
      while (start_o == '0 && n < TIMEOUT)
      begin
         @(negedge clk);
         n++;
      end
      if (start_o == '0)
         fail_run("timeout, no start strobe after the instruction was accepted");
      st = start_o;
      d  = dispatch_o; // valid with the strobe
   endtask

   task automatic free_ports(input logic [3:0] mask);
      @(posedge clk); // start edge
      #1;
      port_done_i = mask;
      @(posedge clk);
      #1;
      port_done_i = '0;
   endtask

   task automatic test_reset();
      @(negedge clk);
      check("reset start_o", 32'h0, 32'(start_o));
      check("reset req_rdy_o", 32'h1, 32'(req_rdy_o));
      check("reset vl_o", 32'd128, vl_o);
      check("reset sew_o", 32'd2, 32'(sew_o));
      check("reset lmul_o", 32'd0, 32'(lmul_o));
   endtask

   task automatic run_cfg(input string tname, input logic [4:0] vd, input logic [4:0] rs1_f,
         input logic [2:0] sew, input logic [2:0] lmul);
      logic [31:0] avl;
      avl = next_rand();
      if (rs1_f != 5'd0)
         cur_vl = avl;                    // requested length
      else if (vd != 5'd0)
         cur_vl = vlmax_ref(sew, lmul);
      send(make_req(vsetvli(vd, rs1_f, sew, lmul), avl, vcu_pkg::CLS_CONFIG));
      @(posedge clk); // config issue edge
      #1;
      check({tname, " vl"}, cur_vl, vl_o);
      check({tname, " sew"}, 32'(sew), 32'(sew_o));
      check({tname, " lmul"}, 32'(lmul), 32'(lmul_o));
      cur_sew = sew;
   endtask

   task automatic test_config();
      run_cfg("vsetvli avl", 5'd1, 5'd5, 3'd1, 3'd1);
      run_cfg("vsetvli vlmax", 5'd2, 5'd0, 3'd0, 3'd2);  // 2048 bytes
      run_cfg("vsetvli frac", 5'd3, 5'd0, 3'd1, 3'd6);   // lmul 1/4
      run_cfg("vsetvli keep", 5'd0, 5'd0, 3'd0, 3'd0);   // vl unchanged
   endtask

   task automatic arith_case(input string tname, input vcu_pkg::instr_req_t r,
         input vcu_pkg::inst_type_e typ, input logic [1:0] sel,
         input vcu_pkg::alu_op_e op, input logic wide);
      vcu_pkg::dispatch_t d;
      logic [3:0]         st;
      logic [1:0]         wd;
      wd = wide ? cur_sew[1:0] + 2'd2 : cur_sew[1:0] + 2'd1;
      send(r);
      wait_start(st, d);
      free_ports(st);
      check({tname, " inst_type"}, 32'(typ), 32'(d.inst_type));
      check({tname, " op2_sel"}, 32'(sel), 32'(d.op2_sel));
      check({tname, " alu_opmode"}, 32'(op), 32'(d.alu_opmode));
      check({tname, " wdata_width"}, 32'(wd), 32'(d.wdata_width));
      check({tname, " reduction"}, 32'(typ == vcu_pkg::INST_REDUCTION), 32'(d.reduction));
      check({tname, " vector_mask"}, 32'(r.instr[25] == 1'b0), 32'(d.vector_mask));
      check({tname, " alu_x_data"}, r.rs1, d.alu_x_data);
      check({tname, " alu_imm"}, 32'(r.instr[19:15]), 32'(d.alu_imm));
   endtask

   task automatic test_arith();
      arith_case("vadd.vv", make_req(op_v(6'b000000, 1'b1, 5'd1, 5'd2, 3'b000, 5'd8),
         next_rand(), vcu_pkg::CLS_OPIVV), vcu_pkg::INST_NORMAL, 2'd0, vcu_pkg::ALU_ADD, 1'b0);
      arith_case("vsub.vx", make_req(op_v(6'b000010, 1'b0, 5'd3, 5'd4, 3'b100, 5'd9),
         next_rand(), vcu_pkg::CLS_OPIVX), vcu_pkg::INST_NORMAL, 2'd1, vcu_pkg::ALU_SUB, 1'b0);
      arith_case("vand.vi", make_req(op_v(6'b001001, 1'b1, 5'd5, 5'd11, 3'b011, 5'd10),
         next_rand(), vcu_pkg::CLS_OPIVI), vcu_pkg::INST_NORMAL, 2'd2, vcu_pkg::ALU_AND, 1'b0);
      arith_case("vwmulu.vv", make_req(op_v(6'b111000, 1'b1, 5'd6, 5'd7, 3'b010, 5'd12),
         next_rand(), vcu_pkg::CLS_OPMVV), vcu_pkg::INST_NORMAL, 2'd0, vcu_pkg::ALU_MULU, 1'b1);
      arith_case("vredsum.vs", make_req(op_v(6'b000000, 1'b1, 5'd16, 5'd17, 3'b010, 5'd13),
         next_rand(), vcu_pkg::CLS_OPMVV), vcu_pkg::INST_REDUCTION, 2'd0, vcu_pkg::ALU_ADD,
         1'b0);
   endtask

   task automatic test_ports();
      vcu_pkg::dispatch_t d;
      logic [3:0]         st;
      for (int i = 0; i < vcu_pkg::W_PORTS_NUM; i++)
      begin
         send(make_req(op_v(6'b000000, 1'b1, 5'd1, 5'd2, 3'b000, 5'(20 + i)), next_rand(),
            vcu_pkg::CLS_OPIVV));
         wait_start(st, d);
         check("port order", 32'(1 << i), 32'(st)); // lowest free port
      end
      send(make_req(op_v(6'b000000, 1'b1, 5'd1, 5'd2, 3'b000, 5'd24), next_rand(),
         vcu_pkg::CLS_OPIVV));
      repeat (3) // all ports taken, fifth sits in the holding register
      begin
         @(negedge clk);
         check("port stall req_rdy_o", 32'h0, 32'(req_rdy_o));
         check("port stall start_o", 32'h0, 32'(start_o));
      end
      free_ports(4'b0100);
      wait_start(st, d);
      check("port reuse", 32'h4, 32'(st));
      free_ports(4'b1111);
   endtask

   task automatic test_dependency();
      vcu_pkg::dispatch_t d;
      logic [3:0]         st;
      int                 t_prod;
      send(make_req(op_v(6'b000000, 1'b1, 5'd1, 5'd2, 3'b000, 5'd26), next_rand(),
         vcu_pkg::CLS_OPIVV));
      wait_start(st, d);
      t_prod = cyc; // producer start cycle
      free_ports(st);
      send(make_req(op_v(6'b000000, 1'b1, 5'd26, 5'd3, 3'b000, 5'd27), next_rand(),
         vcu_pkg::CLS_OPIVV)); // vs2 reads the producer's vd
      wait_start(st, d);
      if (cyc - t_prod < vcu_pkg::DEP_HOLD_CYCLES)
         fail_run("dependent instruction started inside the hold window of its producer");
      free_ports(st);
   endtask

   task automatic slide_case(input string tname, input vcu_pkg::instr_req_t r,
         input logic up, input logic [31:0] amount);
      vcu_pkg::dispatch_t d;
      logic [3:0]         st;
      send(r);
      wait_start(st, d);
      free_ports(st);
      check({tname, " inst_type"}, 32'(vcu_pkg::INST_SLIDE), 32'(d.inst_type));
      check({tname, " up_down_slide"}, 32'(up), 32'(d.up_down_slide));
      check({tname, " slide_amount"}, amount, d.slide_amount);
   endtask

   task automatic test_slides();
      logic [31:0] x;
      run_cfg("vsetvli sew16", 5'd0, 5'd0, 3'd1, 3'd0); // offsets in halfwords
      x = next_rand();
      slide_case("vslidedown.vi", make_req(op_v(6'b001111, 1'b1, 5'd1, 5'd5, 3'b011, 5'd14),
         x, vcu_pkg::CLS_OPIVI), 1'b0, 32'd5 << cur_sew);
      x = next_rand();
      slide_case("vslideup.vi", make_req(op_v(6'b001110, 1'b1, 5'd2, 5'd3, 3'b011, 5'd15),
         x, vcu_pkg::CLS_OPIVI), 1'b1, 32'd3 << cur_sew);
      x = next_rand();
      slide_case("vslidedown.vx", make_req(op_v(6'b001111, 1'b1, 5'd3, 5'd4, 3'b100, 5'd16),
         x, vcu_pkg::CLS_OPIVX), 1'b0, x << cur_sew);
      x = next_rand();
      slide_case("vslideup.vx", make_req(op_v(6'b001110, 1'b1, 5'd4, 5'd5, 3'b100, 5'd17),
         x, vcu_pkg::CLS_OPIVX), 1'b1, x << cur_sew);
   endtask

   initial
   begin
      clk         = 1'b0;
      rstn        = 1'b0;
      cyc         = 0;
      seed        = 69;
      req_i       = '0;
      req_vld_i   = 1'b0;
      port_done_i = '0;
      cur_vl      = 32'd128; // VLEN/32
      cur_sew     = 3'd2;
      repeat (4) @(posedge clk);
      #1;
      rstn = 1'b1;
      test_reset();
      test_config();
      test_arith();
      test_ports();
      test_dependency();
      test_slides();
      $display("TB PASSED");
      $finish;
   end

endmodule

/* vcu_top.sv */
// vector control unit top, issue control, hazard tracker, config registers and decoder
`timescale 1ns/1ps

module vcu_top (
   input  logic                               clk,
   input  logic                               rstn,
   input  vcu_pkg::instr_req_t                req_i,
   input  logic                               req_vld_i,
   output logic                               req_rdy_o,
   output logic [vcu_pkg::W_PORTS_NUM-1:0]    start_o,
   output vcu_pkg::dispatch_t                 dispatch_o,
   input  logic [vcu_pkg::W_PORTS_NUM-1:0]    port_done_i,
   output logic [vcu_pkg::VL_W-1:0]           vl_o,
   output logic [2:0]                         sew_o,
   output logic [2:0]                         lmul_o
);

   vcu_pkg::instr_req_t held;     // instruction waiting to issue
   logic                held_vld;
   logic                issue;    // held instruction leaves
   logic                hazard;
   vcu_pkg::vtype_t     vtype;

   vcu_issue_ctrl vcu_issue_ctrl_inst (
      .clk         (clk),
      .rstn        (rstn),
      .req_i       (req_i),
      .req_vld_i   (req_vld_i),
      .hazard_i    (hazard),
      .port_done_i (port_done_i),
      .req_rdy_o   (req_rdy_o),
      .held_o      (held),
      .held_vld_o  (held_vld),
      .issue_o     (issue),
      .start_o     (start_o)
   );

   vcu_hazard_tracker vcu_hazard_tracker_inst (
      .clk        (clk),
      .rstn       (rstn),
      .held_i     (held),
      .held_vld_i (held_vld),
      .start_i    (start_o),
      .hazard_o   (hazard)
   );

   vcu_vtype_regs vcu_vtype_regs_inst (
      .clk     (clk),
      .rstn    (rstn),
      .held_i  (held),
      .issue_i (issue),
      .vtype_o (vtype),
      .vl_o    (vl_o),
      .sew_o   (sew_o),
      .lmul_o  (lmul_o)
   );

   vcu_decoder vcu_decoder_inst (
      .held_i     (held),
      .vtype_i    (vtype),
      .dispatch_o (dispatch_o)
   );

endmodule

/* vcu_decoder.sv */
// combinational decode of the held instruction into the lane control bundle
`timescale 1ns/1ps

module vcu_decoder (
   input  vcu_pkg::instr_req_t held_i,
   input  vcu_pkg::vtype_t     vtype_i,
   output vcu_pkg::dispatch_t  dispatch_o
);

   logic [5:0]  funct6;
   logic [2:0]  funct6_up;
   logic        is_opi;    // OPIVV/OPIVX/OPIVI
   logic        is_opm;    // OPMVV/OPMVX
   logic        is_vv;
   logic        is_vx;
   logic        is_vi;
   logic        red_chk;
   logic        slide_chk;
   logic        wide_chk;
   logic [2:0]  wd_sum;

   assign funct6    = held_i.instr[31:26];
   assign funct6_up = held_i.instr[31:29];

   assign is_vv  = held_i.cls inside {vcu_pkg::CLS_OPIVV, vcu_pkg::CLS_OPMVV};
   assign is_vx  = held_i.cls inside {vcu_pkg::CLS_OPIVX, vcu_pkg::CLS_OPMVX};
   assign is_vi  = held_i.cls == vcu_pkg::CLS_OPIVI;
   assign is_opi = held_i.cls inside {vcu_pkg::CLS_OPIVV, vcu_pkg::CLS_OPIVX,
                                      vcu_pkg::CLS_OPIVI};
   assign is_opm = held_i.cls inside {vcu_pkg::CLS_OPMVV, vcu_pkg::CLS_OPMVX};

   assign red_chk   = (is_opm && funct6_up == 3'b000) ||
                      (held_i.cls == vcu_pkg::CLS_OPIVV && funct6_up == 3'b110);
   assign slide_chk = (is_opi || is_opm) && (funct6 == 6'b001110 || funct6 == 6'b001111);
   assign wide_chk  = (funct6_up == 3'b111) || (funct6_up == 3'b110); // 2*sew result
   assign wd_sum    = wide_chk ? vtype_i.sew + 3'd2 : vtype_i.sew + 3'd1;

   always_comb
   begin
      dispatch_o = '0;

      // type priority: memory first, then reduction and slide
      if (held_i.cls == vcu_pkg::CLS_STORE)
         dispatch_o.inst_type = vcu_pkg::INST_STORE;
      else if (held_i.cls == vcu_pkg::CLS_LOAD)
         dispatch_o.inst_type = vcu_pkg::INST_LOAD;
      else if (red_chk)
         dispatch_o.inst_type = vcu_pkg::INST_REDUCTION;
      else if (slide_chk)
         dispatch_o.inst_type = vcu_pkg::INST_SLIDE;
      else if (is_opi || is_opm)
         dispatch_o.inst_type = vcu_pkg::INST_NORMAL;
      else
         dispatch_o.inst_type = vcu_pkg::INST_INVALID; // config

      dispatch_o.op2_sel = is_vv ? 2'd0 : is_vx ? 2'd1 : is_vi ? 2'd2 : 2'd3;

      dispatch_o.alu_opmode = vcu_pkg::ALU_ADD; // default
      if (is_opi)
      begin
         case (funct6)
            6'b000010, 6'b000011: dispatch_o.alu_opmode = vcu_pkg::ALU_SUB; // vsub, vrsub
            6'b000100, 6'b011010: dispatch_o.alu_opmode = vcu_pkg::ALU_SLTU;
            6'b000101, 6'b011011: dispatch_o.alu_opmode = vcu_pkg::ALU_SLT;
            6'b000110, 6'b011110: dispatch_o.alu_opmode = vcu_pkg::ALU_SGTU;
            6'b000111, 6'b011111: dispatch_o.alu_opmode = vcu_pkg::ALU_SGT;
            6'b001001: dispatch_o.alu_opmode = vcu_pkg::ALU_AND;
            6'b001010: dispatch_o.alu_opmode = vcu_pkg::ALU_OR;
            6'b001011: dispatch_o.alu_opmode = vcu_pkg::ALU_XOR;
            6'b010010, 6'b010011: dispatch_o.alu_opmode = vcu_pkg::ALU_SUB; // vsbc, vmsbc
            6'b011000: dispatch_o.alu_opmode = vcu_pkg::ALU_SEQ;
            6'b011001: dispatch_o.alu_opmode = vcu_pkg::ALU_SNEQ;
            6'b011100: dispatch_o.alu_opmode = vcu_pkg::ALU_SLEU;
            6'b011101: dispatch_o.alu_opmode = vcu_pkg::ALU_SLE;
            6'b100000: dispatch_o.alu_opmode = vcu_pkg::ALU_ADDU;  // saturating
            6'b100010: dispatch_o.alu_opmode = vcu_pkg::ALU_SUBU;
            6'b100011: dispatch_o.alu_opmode = vcu_pkg::ALU_SUB;
            6'b100101: dispatch_o.alu_opmode = vcu_pkg::ALU_SLL;
            6'b100111: dispatch_o.alu_opmode = vcu_pkg::ALU_MUL;   // vsmul
            6'b101000, 6'b101010, 6'b101100, 6'b101110, 6'b101111:
               dispatch_o.alu_opmode = vcu_pkg::ALU_SRL;           // plain, rounding, narrowing
            6'b101001, 6'b101011, 6'b101101:
               dispatch_o.alu_opmode = vcu_pkg::ALU_SRA;
            default: dispatch_o.alu_opmode = vcu_pkg::ALU_ADD;     // vadd, vadc, vwredsum
         endcase
      end
      else if (is_opm)
      begin
         case (funct6)
            6'b000001, 6'b011001: dispatch_o.alu_opmode = vcu_pkg::ALU_AND;
            6'b000010, 6'b011010: dispatch_o.alu_opmode = vcu_pkg::ALU_OR;
            6'b000011, 6'b011011: dispatch_o.alu_opmode = vcu_pkg::ALU_XOR;
            6'b000100: dispatch_o.alu_opmode = vcu_pkg::ALU_SLTU;  // vredminu
            6'b000101: dispatch_o.alu_opmode = vcu_pkg::ALU_SLT;
            6'b000110: dispatch_o.alu_opmode = vcu_pkg::ALU_SGTU;
            6'b000111: dispatch_o.alu_opmode = vcu_pkg::ALU_SGT;
            6'b001000, 6'b110000, 6'b110100: dispatch_o.alu_opmode = vcu_pkg::ALU_ADDU;
            6'b001010, 6'b110010, 6'b110110: dispatch_o.alu_opmode = vcu_pkg::ALU_SUBU;
            6'b001011, 6'b110011, 6'b110111: dispatch_o.alu_opmode = vcu_pkg::ALU_SUB;
            6'b011000: dispatch_o.alu_opmode = vcu_pkg::ALU_ANDNOT; // mask logic
            6'b011100: dispatch_o.alu_opmode = vcu_pkg::ALU_ORNOT;
            6'b011101: dispatch_o.alu_opmode = vcu_pkg::ALU_NAND;
            6'b011110: dispatch_o.alu_opmode = vcu_pkg::ALU_NOR;
            6'b011111: dispatch_o.alu_opmode = vcu_pkg::ALU_XNOR;
            6'b100100: dispatch_o.alu_opmode = vcu_pkg::ALU_MULHU;
            6'b100101, 6'b111011: dispatch_o.alu_opmode = vcu_pkg::ALU_MUL;
            6'b100110: dispatch_o.alu_opmode = vcu_pkg::ALU_MULHSU;
            6'b100111: dispatch_o.alu_opmode = vcu_pkg::ALU_MULH;
            6'b101001, 6'b101101, 6'b111101: dispatch_o.alu_opmode = vcu_pkg::ALU_MUL_ADD;
            6'b101011, 6'b101111: dispatch_o.alu_opmode = vcu_pkg::ALU_MUL_SUB;
            6'b111000: dispatch_o.alu_opmode = vcu_pkg::ALU_MULU;   // vwmulu
            6'b111010: dispatch_o.alu_opmode = vcu_pkg::ALU_MULSU;
            6'b111100: dispatch_o.alu_opmode = vcu_pkg::ALU_MULU_ADD;
            6'b111110: dispatch_o.alu_opmode = vcu_pkg::ALU_MULUS_ADD;
            6'b111111: dispatch_o.alu_opmode = vcu_pkg::ALU_MULSU_ADD;
            default:   dispatch_o.alu_opmode = vcu_pkg::ALU_ADD;
         endcase
      end

      dispatch_o.wdata_width   = wd_sum[1:0];
      dispatch_o.reduction     = red_chk;
      dispatch_o.vector_mask   = ~held_i.instr[25];  // vm=0 means masked
      dispatch_o.alu_x_data    = held_i.rs1;
      dispatch_o.alu_imm       = held_i.instr[19:15];
      dispatch_o.up_down_slide = (funct6 != 6'b001111);

      // element offset scaled to bytes
      if (is_vi)
         dispatch_o.slide_amount = {27'd0, held_i.instr[19:15]} << vtype_i.sew;
      else if (is_vx)
         dispatch_o.slide_amount = held_i.rs1 << vtype_i.sew;
      else
         dispatch_o.slide_amount = 32'd1 << vtype_i.sew; // slide1up/down
   end

endmodule

/* vcu_vtype_regs.sv */
// vtype and vl configuration registers with vsetvl/vsetvli update
`timescale 1ns/1ps

module vcu_vtype_regs (
   input  logic                     clk,
   input  logic                     rstn,
   input  vcu_pkg::instr_req_t      held_i,
   input  logic                     issue_i,
   output vcu_pkg::vtype_t          vtype_o,
   output logic [vcu_pkg::VL_W-1:0] vl_o,
   output logic [2:0]               sew_o,
   output logic [2:0]               lmul_o
);

   vcu_pkg::vtype_t          vtype_q;
   vcu_pkg::vtype_t          vtype_next;
   logic [vcu_pkg::VL_W-1:0] vl_q;
   logic [vcu_pkg::VL_W-1:0] vl_next;
   logic [vcu_pkg::VL_W-1:0] vlmax;
   logic                     cfg_issue;
   logic [4:0]               rs1_field;
   logic [4:0]               vd_field;

   assign cfg_issue = issue_i && (held_i.cls == vcu_pkg::CLS_CONFIG);
   assign rs1_field = held_i.instr[19:15];
   assign vd_field  = held_i.instr[11:7];

   always_comb
   begin
      vtype_next = '0;
      if (held_i.instr[31:30] == 2'b10) // vsetvl, vtype in rs1
         vtype_next = vcu_pkg::vtype_t'(held_i.rs1);
      else
      begin
         vtype_next.lmul = {held_i.instr[25], held_i.instr[21:20]};
         vtype_next.sew  = held_i.instr[24:22];
         vtype_next.vta  = held_i.instr[26];
         vtype_next.vma  = held_i.instr[27];
      end
   end

   // lookup uses the new vtype, not the current one
   assign vlmax = vcu_pkg::VLMAX_TBL[vtype_next.lmul][vtype_next.sew];

   assign vl_next = (rs1_field != 5'd0) ? held_i.rs1 : // requested avl
                    (vd_field != 5'd0)  ? vlmax :
                                          vl_q;         // keep vl

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         vtype_q      <= '0;
         vtype_q.sew  <= 3'd2; // 32-bit elements
         vl_q         <= vcu_pkg::VL_W'(vcu_pkg::RESET_VL);
      end
      else if (cfg_issue)
      begin
         vtype_q <= vtype_next;
         vl_q    <= vl_next;
      end
   end

   assign vtype_o = vtype_q;
   assign vl_o    = vl_q;
   assign sew_o   = vtype_q.sew;
   assign lmul_o  = vtype_q.lmul;

endmodule

/* vcu_hazard_tracker.sv */
// per-port destination scoreboard with hold countdowns and source match
`timescale 1ns/1ps

module vcu_hazard_tracker (
   input  logic                            clk,
   input  logic                            rstn,
   input  vcu_pkg::instr_req_t             held_i,
   input  logic                            held_vld_i,
   input  logic [vcu_pkg::W_PORTS_NUM-1:0] start_i,
   output logic                            hazard_o
);

   logic [vcu_pkg::W_PORTS_NUM-1:0][4:0]                  vd_q;  // pending destination per port
   logic [vcu_pkg::W_PORTS_NUM-1:0]                       vld_q;
   logic [vcu_pkg::W_PORTS_NUM-1:0][vcu_pkg::DEP_CNT_W-1:0] cnt_q;
   logic [vcu_pkg::W_PORTS_NUM-1:0]                       match;
   logic                                                  chk_vs1;

   always_ff @(posedge clk)
   begin
      for (int i = 0; i < vcu_pkg::W_PORTS_NUM; i++)
      begin
         if (!rstn)
         begin
            vld_q[i] <= 1'b0;
            cnt_q[i] <= '0;
         end
         else if (start_i[i]) // load on start edge
         begin
            vd_q[i]  <= held_i.instr[11:7];
            vld_q[i] <= 1'b1;
            cnt_q[i] <= vcu_pkg::DEP_CNT_W'(vcu_pkg::DEP_HOLD_CYCLES);
         end
         else if (vld_q[i])
         begin
            cnt_q[i] <= cnt_q[i] - 1'b1;
            if (cnt_q[i] == vcu_pkg::DEP_CNT_W'(1))
               vld_q[i] <= 1'b0; // count hits zero
         end
      end
   end

   // vs1 is a register only in the vector-vector forms
   assign chk_vs1 = held_i.cls inside {vcu_pkg::CLS_OPIVV, vcu_pkg::CLS_OPMVV};

   always_comb
   begin
      for (int i = 0; i < vcu_pkg::W_PORTS_NUM; i++)
         match[i] = vld_q[i] && ((vd_q[i] == held_i.instr[24:20]) ||
                                 (chk_vs1 && vd_q[i] == held_i.instr[19:15]));
   end

   assign hazard_o = held_vld_i && (held_i.cls != vcu_pkg::CLS_CONFIG) && (|match);

endmodule

/* vcu_issue_ctrl.sv */
// instruction holding register, accept handshake, port busy bits and start strobes
`timescale 1ns/1ps

module vcu_issue_ctrl (
   input  logic                            clk,
   input  logic                            rstn,
   input  vcu_pkg::instr_req_t             req_i,
   input  logic                            req_vld_i,
   input  logic                            hazard_i,
   input  logic [vcu_pkg::W_PORTS_NUM-1:0] port_done_i,
   output logic                            req_rdy_o,
   output vcu_pkg::instr_req_t             held_o,
   output logic                            held_vld_o,
   output logic                            issue_o,
   output logic [vcu_pkg::W_PORTS_NUM-1:0] start_o
);

   logic [vcu_pkg::W_PORTS_NUM-1:0] busy_q;
   logic [vcu_pkg::W_PORTS_NUM-1:0] free;
   logic [vcu_pkg::W_PORTS_NUM-1:0] grant;   // lowest free port, one-hot
   logic                            is_cfg;
   logic                            accept;

   assign is_cfg = held_o.cls == vcu_pkg::CLS_CONFIG;
   assign free   = ~busy_q;
   assign grant  = free & (~free + 1'b1);   // isolate lowest set bit

   // config bypasses hazards and ports
   assign issue_o   = held_vld_o && (is_cfg || (!hazard_i && (|free)));
   assign start_o   = (issue_o && !is_cfg) ? grant : '0;
   assign req_rdy_o = !held_vld_o || issue_o; // refill while leaving
   assign accept    = req_vld_i && req_rdy_o;

   always_ff @(posedge clk)
   begin
      if (!rstn)
      begin
         held_vld_o <= 1'b0;
         busy_q     <= '0;
      end
      else
      begin
         held_vld_o <= accept || (held_vld_o && !issue_o);
         // start wins over a same-cycle done
         busy_q     <= (busy_q & ~port_done_i) | start_o;
      end
   end

   always_ff @(posedge clk)
   begin
      if (accept)
         held_o <= req_i;
   end

endmodule

/* vcu_pkg.sv */
// vector unit localparams, class/type/opmode enums, vtype/request/dispatch structs, vlmax table
package vcu_pkg;

   localparam int VLEN            = 4096;      // bits per vector register
   localparam int W_PORTS_NUM     = 4;         // write-port groups
   localparam int DEP_HOLD_CYCLES = 9;         // scoreboard hold after start
   localparam int DEP_CNT_W       = $clog2(DEP_HOLD_CYCLES + 1);
   localparam int ALU_OPMODE_W    = 9;
   localparam int VL_W            = 32;
   localparam int RESET_VL        = VLEN / 32; // sew 2, lmul 0

   // one class per scheduler queue
   typedef enum logic [3:0] {
      CLS_OPIVV  = 4'd0,
      CLS_OPIVX  = 4'd1,
      CLS_OPIVI  = 4'd2,
      CLS_OPMVV  = 4'd3,
      CLS_OPMVX  = 4'd4,
      CLS_LOAD   = 4'd5,
      CLS_STORE  = 4'd6,
      CLS_CONFIG = 4'd7
   } instr_class_e;

   typedef enum logic [2:0] {
      INST_NORMAL    = 3'd0,
      INST_REDUCTION = 3'd1,
      INST_STORE     = 3'd2,
      INST_LOAD      = 3'd4,
      INST_SLIDE     = 3'd6,
      INST_INVALID   = 3'd7
   } inst_type_e;

   // upper bits pick the alu unit, lower bits the op
   typedef enum logic [ALU_OPMODE_W-1:0] {
      ALU_ADD       = 9'h000,
      ALU_ADDU      = 9'h001,
      ALU_SUB       = 9'h002,
      ALU_SUBU      = 9'h003,
      ALU_SLT       = 9'h040, // compares
      ALU_SLTU      = 9'h041,
      ALU_SLE       = 9'h042,
      ALU_SLEU      = 9'h043,
      ALU_SGT       = 9'h044,
      ALU_SGTU      = 9'h045,
      ALU_SEQ       = 9'h046,
      ALU_SNEQ      = 9'h047,
      ALU_AND       = 9'h080, // logic
      ALU_OR        = 9'h081,
      ALU_XOR       = 9'h082,
      ALU_ANDNOT    = 9'h083,
      ALU_ORNOT     = 9'h084,
      ALU_NAND      = 9'h085,
      ALU_NOR       = 9'h086,
      ALU_XNOR      = 9'h087,
      ALU_SLL       = 9'h0c0, // shifts
      ALU_SRL       = 9'h0c1,
      ALU_SRA       = 9'h0c2,
      ALU_MUL       = 9'h100, // multiplier
      ALU_MULH      = 9'h101,
      ALU_MULHU     = 9'h102,
      ALU_MULHSU    = 9'h103,
      ALU_MULU      = 9'h104,
      ALU_MULSU     = 9'h105,
      ALU_MUL_ADD   = 9'h140, // multiply-accumulate
      ALU_MULU_ADD  = 9'h141,
      ALU_MULUS_ADD = 9'h142,
      ALU_MULSU_ADD = 9'h143,
      ALU_MUL_SUB   = 9'h144
   } alu_op_e;

   typedef struct packed {
      logic        vill;  // illegal config
      logic [22:0] rsvd;
      logic        vma;
      logic        vta;
      logic [2:0]  sew;
      logic [2:0]  lmul;
   } vtype_t;

   typedef struct packed {
      logic [31:0]  instr;
      logic [31:0]  rs1;   // scalar operand
      instr_class_e cls;
   } instr_req_t;

   typedef struct packed {
      inst_type_e  inst_type;
      logic [1:0]  op2_sel;      // 0 vv, 1 vx, 2 vi
      alu_op_e     alu_opmode;
      logic [1:0]  wdata_width;
      logic        reduction;
      logic        vector_mask;
      logic [31:0] alu_x_data;
      logic [4:0]  alu_imm;
      logic        up_down_slide; // low for slidedown
      logic [31:0] slide_amount;  // in bytes
   } dispatch_t;

   // vlmax indexed [lmul][sew]
   typedef logic [7:0][7:0][VL_W-1:0] vlmax_tbl_t;

   function automatic vlmax_tbl_t build_vlmax();
      vlmax_tbl_t tbl;
      tbl = '0;
      for (int l = 0; l < 4; l++)
      begin
         for (int s = 0; s < 4; s++)
            tbl[l][s] = VL_W'(((VLEN / 8) / (2 ** s)) * (2 ** l));
      end
      // fractional lmul, 5..7 mean 1/8..1/2
      for (int l = 5; l < 8; l++)
      begin
         for (int s = 0; s < 4; s++)
            tbl[l][s] = VL_W'(((VLEN / 8) / (2 ** s)) / (2 ** (8 - l)));
      end
      return tbl;
   endfunction

   localparam vlmax_tbl_t VLMAX_TBL = build_vlmax();

endpackage
